// ==== common/test_mem_defines.svh ====
// Memory geometry and message field widths for the test memory.
// Data width must be a multiple of 8 and memory size a power of two.

`ifndef TEST_MEM_DEFINES_SVH
`define TEST_MEM_DEFINES_SVH

// Physical memory size in bytes, upper address bits are dropped
`define TM_MEM_NBYTES 1024

// Opaque tag, returned unchanged in the response
`define TM_OPAQUE_NBITS 8

// Request byte address
`define TM_ADDR_NBITS 32

// Data word, also the access granule of the array
`define TM_DATA_NBITS 32

`endif

// ==== common/test_mem_pkg.sv ====
// Message field types for the test memory ports.
// Widths come from the defines header, packed widths are derived here.

`include "test_mem_defines.svh"

package test_mem_pkg;

  // Request type, value 2 is reserved and acts as a no-op
  typedef enum logic [2:0] {
    REQ_READ    = 3'd0,
    REQ_WRITE   = 3'd1,
    REQ_AMO_ADD = 3'd3,
    REQ_AMO_AND = 3'd4,
    REQ_AMO_OR  = 3'd5
  } req_type_e;

  // ----------------------------------------------------------------------------
  // Message fields
  // ----------------------------------------------------------------------------

  typedef logic [`TM_OPAQUE_NBITS-1:0]           opaque_t;
  typedef logic [`TM_ADDR_NBITS-1:0]             addr_t;
  // Byte count, 0 stands for a full word
  typedef logic [$clog2(`TM_DATA_NBITS/8)-1:0]   len_t;
  typedef logic [`TM_DATA_NBITS-1:0]             data_t;

  // ----------------------------------------------------------------------------
  // Internal array addressing
  // ----------------------------------------------------------------------------

  typedef logic [$clog2(`TM_MEM_NBYTES/(`TM_DATA_NBITS/8))-1:0] word_addr_t;
  typedef logic [`TM_DATA_NBITS/8-1:0]                          byte_en_t;

  // Packed widths: request is {type, opaque, addr, len, data}
  localparam int REQ_NBITS = $bits(req_type_e) + $bits(opaque_t) + $bits(addr_t)
                           + $bits(len_t) + $bits(data_t);

  // Response is {type, opaque, len, data}
  localparam int RESP_NBITS = $bits(req_type_e) + $bits(opaque_t) + $bits(len_t)
                            + $bits(data_t);

endpackage

// ==== hdl/bypass_buffer.sv ====
// One-entry bypass queue.
// An empty buffer passes the message through in the same cycle, so
// deq_val_o and deq_msg_o depend combinationally on the enqueue side.

`timescale 1ns/1ps

module bypass_buffer #(
  parameter int MSG_NBITS = 8
) (
  input  logic                 clk,
  input  logic                 reset,

  input  logic                 enq_val_i,
  output logic                 enq_rdy_o,
  input  logic [MSG_NBITS-1:0] enq_msg_i,

  output logic                 deq_val_o,
  input  logic                 deq_rdy_i,
  output logic [MSG_NBITS-1:0] deq_msg_o
);

  logic                 full;
  logic [MSG_NBITS-1:0] msg_q;
  logic                 capture;

  // Only an empty buffer takes a message
  assign enq_rdy_o = !full;

  // Held entry goes out first, otherwise straight through
  assign deq_val_o = full || enq_val_i;
  assign deq_msg_o = full ? msg_q : enq_msg_i;

  // Keep the message when the sink refuses the pass-through
  assign capture = enq_val_i && !full && !deq_rdy_i;

  always_ff @(posedge clk) begin
    if (!reset) begin
      full <= 1'b0;
    end else if (capture) begin
      full <= 1'b1;
    end else if (full && deq_rdy_i) begin
      full <= 1'b0;
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (capture) begin
      msg_q <= enq_msg_i;
    end
  end

endmodule

// ==== hdl/pipe_buffer.sv ====
// One-entry pipe queue with full throughput.
// A new entry is accepted in the cycle the held entry is dequeued, so
// enq_rdy_o depends combinationally on deq_rdy_i.

`timescale 1ns/1ps

module pipe_buffer #(
  parameter int MSG_NBITS = 8
) (
  input  logic                 clk,
  input  logic                 reset,

  input  logic                 enq_val_i,
  output logic                 enq_rdy_o,
  input  logic [MSG_NBITS-1:0] enq_msg_i,

  output logic                 deq_val_o,
  input  logic                 deq_rdy_i,
  output logic [MSG_NBITS-1:0] deq_msg_o
);

  logic                 full;
  logic [MSG_NBITS-1:0] msg_q;
  logic                 enq_fire;

  // Room when empty or when the entry leaves this cycle
  assign enq_rdy_o = !full || deq_rdy_i;
  assign enq_fire  = enq_val_i && enq_rdy_o;

  assign deq_val_o = full;
  assign deq_msg_o = msg_q;

  // Full flag
  always_ff @(posedge clk) begin
    if (!reset) begin
      full <= 1'b0;
    end else if (enq_fire) begin
      full <= 1'b1;
    end else if (deq_rdy_i) begin
      // Drains only when nothing new arrives
      full <= 1'b0;
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (enq_fire) begin
      msg_q <= enq_msg_i;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module test_mem_2port_tb \
  -f test_mem_2port.f \
  -o test_mem_2port_sim

output="$(./obj_dir/test_mem_2port_sim)"
echo "$output"

if echo "$output" | grep -qx "NO ERRORS"; then
  exit 0
else
  exit 1
fi

// ==== test_mem/mem_array.sv ====
// Word storage for the two-port test memory, no reset of contents.
// Reads are combinational, writes land at the next edge.
// Port 1 wins on overlapping bytes; clear overrides both ports.

`timescale 1ns/1ps

`include "test_mem_defines.svh"

module mem_array (
  input  logic                     clk,
  input  logic                     mem_clear_i,

  // Port 0
  input  test_mem_pkg::word_addr_t addr0_i,
  input  logic                     wr_en0_i,
  input  test_mem_pkg::byte_en_t   be0_i,
  input  test_mem_pkg::data_t      wdata0_i,
  output test_mem_pkg::data_t      rdata0_o,

  // Port 1
  input  test_mem_pkg::word_addr_t addr1_i,
  input  logic                     wr_en1_i,
  input  test_mem_pkg::byte_en_t   be1_i,
  input  test_mem_pkg::data_t      wdata1_i,
  output test_mem_pkg::data_t      rdata1_o
);

  import test_mem_pkg::*;

  localparam int NBYTES = `TM_DATA_NBITS / 8;
  localparam int NWORDS = `TM_MEM_NBYTES / NBYTES;

  data_t mem [NWORDS];

  // Old contents seen by both ports during the cycle
  assign rdata0_o = mem[addr0_i];
  assign rdata1_o = mem[addr1_i];

  always_ff @(posedge clk) begin
    if (mem_clear_i) begin
      // Zero the whole array in one cycle
      for (int w = 0; w < NWORDS; w++) begin
        mem[w] <= '0;
      end
    end else begin
      for (int b = 0; b < NBYTES; b++) begin
        if (wr_en0_i && be0_i[b]) begin
          mem[addr0_i][8*b +: 8] <= wdata0_i[8*b +: 8];
        end
      end
      // Later assignment, so port 1 overrides port 0
      for (int b = 0; b < NBYTES; b++) begin
        if (wr_en1_i && be1_i[b]) begin
          mem[addr1_i][8*b +: 8] <= wdata1_i[8*b +: 8];
        end
      end
    end
  end

endmodule

// ==== test_mem/mem_port_exec.sv ====
// Execution logic for one memory port, purely combinational.
// Accesses must not cross a word; bytes past the word end are dropped.
// Atomics work on whole aligned words and return the old word.

`timescale 1ns/1ps

`include "test_mem_defines.svh"

module mem_port_exec (
  // Middle-stage request, valid only when it fires this cycle
  input  logic                    req_val_i,
  input  test_mem_pkg::req_type_e req_type_i,
  input  test_mem_pkg::addr_t     req_addr_i,
  input  test_mem_pkg::len_t      req_len_i,
  input  test_mem_pkg::data_t     req_data_i,

  // Word read from the array, before this cycle's writes
  input  test_mem_pkg::data_t     rd_word_i,

  output test_mem_pkg::word_addr_t word_addr_o,
  output logic                     wr_en_o,
  output test_mem_pkg::byte_en_t   wr_be_o,
  output test_mem_pkg::data_t      wr_data_o,
  output test_mem_pkg::data_t      resp_data_o
);

  import test_mem_pkg::*;

  // ----------------------------------------------------------------------------
  // Address split
  // ----------------------------------------------------------------------------

  localparam int NBYTES     = `TM_DATA_NBITS / 8;
  localparam int PHYS_NBITS = $clog2(`TM_MEM_NBYTES);
  localparam int OFF_NBITS  = $clog2(NBYTES);

  logic [PHYS_NBITS-1:0] phys_addr;
  logic [OFF_NBITS-1:0]  byte_off;
  logic [OFF_NBITS+2:0]  bit_off;
  logic [OFF_NBITS:0]    nbytes;
  logic [NBYTES:0]       len_mask;
  byte_en_t              write_be;

  // Upper address bits beyond the physical size are ignored
  assign phys_addr   = req_addr_i[PHYS_NBITS-1:0];
  assign word_addr_o = phys_addr[PHYS_NBITS-1:OFF_NBITS];
  assign byte_off    = phys_addr[OFF_NBITS-1:0];
  assign bit_off     = {byte_off, 3'b000};

  // Length 0 means a full word
  assign nbytes = (req_len_i == '0) ? (OFF_NBITS+1)'(NBYTES) : {1'b0, req_len_i};

  // One bit per byte of the access, then moved to the offset
  assign len_mask = ({{NBYTES{1'b0}}, 1'b1} << nbytes) - 1'b1;
  assign write_be = byte_en_t'(len_mask[NBYTES-1:0] << byte_off);

  // ----------------------------------------------------------------------------
  // Response data and write forming
  // ----------------------------------------------------------------------------

  always_comb begin
    wr_en_o     = 1'b0;
    wr_be_o     = '0;
    wr_data_o   = '0;
    resp_data_o = rd_word_i >> bit_off;

    case (req_type_i)
      REQ_READ: begin
        // Nothing to write
      end
      REQ_WRITE: begin
        wr_en_o   = req_val_i;
        wr_be_o   = write_be;
        wr_data_o = req_data_i << bit_off;
      end
      // Atomics replace the whole word
      REQ_AMO_ADD: begin
        wr_en_o   = req_val_i;
        wr_be_o   = '1;
        wr_data_o = rd_word_i + req_data_i;
      end
      REQ_AMO_AND: begin
        wr_en_o   = req_val_i;
        wr_be_o   = '1;
        wr_data_o = rd_word_i & req_data_i;
      end
      REQ_AMO_OR: begin
        wr_en_o   = req_val_i;
        wr_be_o   = '1;
        wr_data_o = rd_word_i | req_data_i;
      end
      default: begin
        // Reserved type, no access and zero data back
        resp_data_o = '0;
      end
    endcase
  end

endmodule

// ==== test_mem/test_mem_2port.sv ====
// Dual-ported test memory with valid/ready request and response ports.
// Latency is one cycle; up to two requests per port are in flight.
// Memory contents are not reset, only the port buffers.

`timescale 1ns/1ps

module test_mem_2port (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    mem_clear_i,

  // Port 0 requests
  input  logic                    memreq0_val_i,
  output logic                    memreq0_rdy_o,
  input  test_mem_pkg::req_type_e memreq0_type_i,
  input  test_mem_pkg::opaque_t   memreq0_opaque_i,
  input  test_mem_pkg::addr_t     memreq0_addr_i,
  input  test_mem_pkg::len_t      memreq0_len_i,
  input  test_mem_pkg::data_t     memreq0_data_i,

  // Port 0 responses
  output logic                    memresp0_val_o,
  input  logic                    memresp0_rdy_i,
  output test_mem_pkg::req_type_e memresp0_type_o,
  output test_mem_pkg::opaque_t   memresp0_opaque_o,
  output test_mem_pkg::len_t      memresp0_len_o,
  output test_mem_pkg::data_t     memresp0_data_o,

  // Port 1 requests
  input  logic                    memreq1_val_i,
  output logic                    memreq1_rdy_o,
  input  test_mem_pkg::req_type_e memreq1_type_i,
  input  test_mem_pkg::opaque_t   memreq1_opaque_i,
  input  test_mem_pkg::addr_t     memreq1_addr_i,
  input  test_mem_pkg::len_t      memreq1_len_i,
  input  test_mem_pkg::data_t     memreq1_data_i,

  // Port 1 responses
  output logic                    memresp1_val_o,
  input  logic                    memresp1_rdy_i,
  output test_mem_pkg::req_type_e memresp1_type_o,
  output test_mem_pkg::opaque_t   memresp1_opaque_o,
  output test_mem_pkg::len_t      memresp1_len_o,
  output test_mem_pkg::data_t     memresp1_data_o
);

  import test_mem_pkg::*;

  localparam int TYPE_NBITS = $bits(req_type_e);

  // ----------------------------------------------------------------------------
  // Port 0
  // ----------------------------------------------------------------------------

  logic [REQ_NBITS-1:0]  req0_msg_m;
  logic [RESP_NBITS-1:0] resp0_msg;
  logic [TYPE_NBITS-1:0] req0_type_raw;
  logic [TYPE_NBITS-1:0] resp0_type_raw;
  logic                  req0_val_m;
  logic                  resp0_enq_rdy;
  logic                  exec0_fire;
  opaque_t               req0_opaque_m;
  addr_t                 req0_addr_m;
  len_t                  req0_len_m;
  data_t                 req0_data_m;
  word_addr_t            word0_addr;
  logic                  wr0_en;
  byte_en_t              wr0_be;
  data_t                 wr0_data;
  data_t                 rd0_word;
  data_t                 resp0_data_m;

  // Registered input stage
  pipe_buffer #(.MSG_NBITS(REQ_NBITS)) u_req0_buf (
    .clk       (clk),
    .reset     (reset),
    .enq_val_i (memreq0_val_i),
    .enq_rdy_o (memreq0_rdy_o),
    .enq_msg_i ({memreq0_type_i, memreq0_opaque_i, memreq0_addr_i,
                 memreq0_len_i, memreq0_data_i}),
    .deq_val_o (req0_val_m),
    .deq_rdy_i (resp0_enq_rdy),
    .deq_msg_o (req0_msg_m)
  );

  assign {req0_type_raw, req0_opaque_m, req0_addr_m, req0_len_m, req0_data_m} = req0_msg_m;

  // Operation executes only when its response can be queued
  assign exec0_fire = req0_val_m && resp0_enq_rdy;

  mem_port_exec u_exec0 (
    .req_val_i   (exec0_fire),
    .req_type_i  (req_type_e'(req0_type_raw)),
    .req_addr_i  (req0_addr_m),
    .req_len_i   (req0_len_m),
    .req_data_i  (req0_data_m),
    .rd_word_i   (rd0_word),
    .word_addr_o (word0_addr),
    .wr_en_o     (wr0_en),
    .wr_be_o     (wr0_be),
    .wr_data_o   (wr0_data),
    .resp_data_o (resp0_data_m)
  );

  // Response goes straight out unless the sink stalls
  bypass_buffer #(.MSG_NBITS(RESP_NBITS)) u_resp0_buf (
    .clk       (clk),
    .reset     (reset),
    .enq_val_i (req0_val_m),
    .enq_rdy_o (resp0_enq_rdy),
    .enq_msg_i ({req0_type_raw, req0_opaque_m, req0_len_m, resp0_data_m}),
    .deq_val_o (memresp0_val_o),
    .deq_rdy_i (memresp0_rdy_i),
    .deq_msg_o (resp0_msg)
  );

  assign {resp0_type_raw, memresp0_opaque_o, memresp0_len_o, memresp0_data_o} = resp0_msg;
  assign memresp0_type_o = req_type_e'(resp0_type_raw);

  // ----------------------------------------------------------------------------
  // Port 1
  // ----------------------------------------------------------------------------

  logic [REQ_NBITS-1:0]  req1_msg_m;
  logic [RESP_NBITS-1:0] resp1_msg;
  logic [TYPE_NBITS-1:0] req1_type_raw;
  logic [TYPE_NBITS-1:0] resp1_type_raw;
  logic                  req1_val_m;
  logic                  resp1_enq_rdy;
  logic                  exec1_fire;
  opaque_t               req1_opaque_m;
  addr_t                 req1_addr_m;
  len_t                  req1_len_m;
  data_t                 req1_data_m;
  word_addr_t            word1_addr;
  logic                  wr1_en;
  byte_en_t              wr1_be;
  data_t                 wr1_data;
  data_t                 rd1_word;
  data_t                 resp1_data_m;

  pipe_buffer #(.MSG_NBITS(REQ_NBITS)) u_req1_buf (
    .clk       (clk),
    .reset     (reset),
    .enq_val_i (memreq1_val_i),
    .enq_rdy_o (memreq1_rdy_o),
    .enq_msg_i ({memreq1_type_i, memreq1_opaque_i, memreq1_addr_i,
                 memreq1_len_i, memreq1_data_i}),
    .deq_val_o (req1_val_m),
    .deq_rdy_i (resp1_enq_rdy),
    .deq_msg_o (req1_msg_m)
  );

  assign {req1_type_raw, req1_opaque_m, req1_addr_m, req1_len_m, req1_data_m} = req1_msg_m;

  assign exec1_fire = req1_val_m && resp1_enq_rdy;

  mem_port_exec u_exec1 (
    .req_val_i   (exec1_fire),
    .req_type_i  (req_type_e'(req1_type_raw)),
    .req_addr_i  (req1_addr_m),
    .req_len_i   (req1_len_m),
    .req_data_i  (req1_data_m),
    .rd_word_i   (rd1_word),
    .word_addr_o (word1_addr),
    .wr_en_o     (wr1_en),
    .wr_be_o     (wr1_be),
    .wr_data_o   (wr1_data),
    .resp_data_o (resp1_data_m)
  );

  bypass_buffer #(.MSG_NBITS(RESP_NBITS)) u_resp1_buf (
    .clk       (clk),
    .reset     (reset),
    .enq_val_i (req1_val_m),
    .enq_rdy_o (resp1_enq_rdy),
    .enq_msg_i ({req1_type_raw, req1_opaque_m, req1_len_m, resp1_data_m}),
    .deq_val_o (memresp1_val_o),
    .deq_rdy_i (memresp1_rdy_i),
    .deq_msg_o (resp1_msg)
  );

  assign {resp1_type_raw, memresp1_opaque_o, memresp1_len_o, memresp1_data_o} = resp1_msg;
  assign memresp1_type_o = req_type_e'(resp1_type_raw);

  // ----------------------------------------------------------------------------
  // Shared array
  // ----------------------------------------------------------------------------

  mem_array u_mem_array (
    .clk         (clk),
    .mem_clear_i (mem_clear_i),
    .addr0_i     (word0_addr),
    .wr_en0_i    (wr0_en),
    .be0_i       (wr0_be),
    .wdata0_i    (wr0_data),
    .rdata0_o    (rd0_word),
    .addr1_i     (word1_addr),
    .wr_en1_i    (wr1_en),
    .be1_i       (wr1_be),
    .wdata1_i    (wr1_data),
    .rdata1_o    (rd1_word)
  );

endmodule

// ==== test_mem_2port.f ====
+incdir+common
common/test_mem_pkg.sv
hdl/pipe_buffer.sv
hdl/bypass_buffer.sv
test_mem/mem_port_exec.sv
test_mem/mem_array.sv
test_mem/test_mem_2port.sv
verif/test_mem_2port_tb.sv

// ==== verif/test_mem_2port_tb.sv ====
// Random testbench for the dual-ported test memory.
// Port 0 traffic stays in the lower half of memory and port 1 in the upper
// half, so a byte model per request transfer predicts every response.
// Needs a simulator with timing support for the clock and the waits.

`timescale 1ns/1ps

`include "test_mem_defines.svh"

module test_mem_2port_tb;

  import test_mem_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int HALF_NBYTES    = `TM_MEM_NBYTES / 2;

  logic      clk = 1'b0;
  logic      reset;
  logic      mem_clear;

  logic      memreq0_val;
  logic      memreq0_rdy;
  req_type_e memreq0_type;
  opaque_t   memreq0_opaque;
  addr_t     memreq0_addr;
  len_t      memreq0_len;
  data_t     memreq0_data;
  logic      memresp0_val;
  logic      memresp0_rdy = 1'b1;
  req_type_e memresp0_type;
  opaque_t   memresp0_opaque;
  len_t      memresp0_len;
  data_t     memresp0_data;

  logic      memreq1_val;
  logic      memreq1_rdy;
  req_type_e memreq1_type;
  opaque_t   memreq1_opaque;
  addr_t     memreq1_addr;
  len_t      memreq1_len;
  data_t     memreq1_data;
  logic      memresp1_val;
  logic      memresp1_rdy = 1'b1;
  req_type_e memresp1_type;
  opaque_t   memresp1_opaque;
  len_t      memresp1_len;
  data_t     memresp1_data;

  // Byte model and expected responses packed as {type, opaque, len, data}
  logic [7:0]            model_mem [`TM_MEM_NBYTES];
  logic [RESP_NBITS-1:0] exp0_q [$];
  logic [RESP_NBITS-1:0] exp1_q [$];

  int   seed = 32'h2262;
  int   checks = 0;
  int   errors = 0;
  logic bp_on = 1'b0;

  always #4 clk = ~clk;

  test_mem_2port u_test_mem_2port (
    .clk               (clk),
    .reset             (reset),
    .mem_clear_i       (mem_clear),
    .memreq0_val_i     (memreq0_val),
    .memreq0_rdy_o     (memreq0_rdy),
    .memreq0_type_i    (memreq0_type),
    .memreq0_opaque_i  (memreq0_opaque),
    .memreq0_addr_i    (memreq0_addr),
    .memreq0_len_i     (memreq0_len),
    .memreq0_data_i    (memreq0_data),
    .memresp0_val_o    (memresp0_val),
    .memresp0_rdy_i    (memresp0_rdy),
    .memresp0_type_o   (memresp0_type),
    .memresp0_opaque_o (memresp0_opaque),
    .memresp0_len_o    (memresp0_len),
    .memresp0_data_o   (memresp0_data),
    .memreq1_val_i     (memreq1_val),
    .memreq1_rdy_o     (memreq1_rdy),
    .memreq1_type_i    (memreq1_type),
    .memreq1_opaque_i  (memreq1_opaque),
    .memreq1_addr_i    (memreq1_addr),
    .memreq1_len_i     (memreq1_len),
    .memreq1_data_i    (memreq1_data),
    .memresp1_val_o    (memresp1_val),
    .memresp1_rdy_i    (memresp1_rdy),
    .memresp1_type_o   (memresp1_type),
    .memresp1_opaque_o (memresp1_opaque),
    .memresp1_len_o    (memresp1_len),
    .memresp1_data_o   (memresp1_data)
  );

  // ----------------------------------------------------------------------------
  // Checking and reference model
  // ----------------------------------------------------------------------------

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic abort_run(input string reason);
    errors++;
    $display("%s", reason);
    $display("%0d checks, %0d errors", checks, errors);
    $display("ERRORS FOUND");
    $finish;
  endtask

  function automatic void clear_model();
    for (int i = 0; i < `TM_MEM_NBYTES; i++) begin
      model_mem[i] = 8'h00;
    end
  endfunction

  // Applies one request to the byte model, returns the expected response data
  function automatic data_t apply_to_model(input req_type_e t, input addr_t a,
                                           input len_t l, input data_t d);
    int    phys;
    int    base;
    int    off;
    int    n;
    data_t old_word;
    data_t new_word;
    data_t resp;
    phys = int'(a % `TM_MEM_NBYTES);
    off  = phys % 4;
    base = phys - off;
    n    = (l == '0) ? 4 : int'(l);
    for (int b = 0; b < 4; b++) begin
      old_word[8*b +: 8] = model_mem[base + b];
    end
    new_word = old_word;
    // Old word seen from the byte offset
    resp = old_word >> (8 * off);
    case (t)
      REQ_READ: begin
      end
      REQ_WRITE: begin
        for (int i = 0; i < n; i++) begin
          if (off + i < 4) begin
            new_word[8*(off + i) +: 8] = d[8*i +: 8];
          end
        end
      end
      REQ_AMO_ADD: new_word = old_word + d;
      REQ_AMO_AND: new_word = old_word & d;
      REQ_AMO_OR:  new_word = old_word | d;
      default:     resp = '0;
    endcase
    for (int b = 0; b < 4; b++) begin
      model_mem[base + b] = new_word[8*b +: 8];
    end
    return resp;
  endfunction

  task automatic check_resp(input int port, input req_type_e t, input opaque_t op,
                            input len_t l, input data_t d);
    logic [RESP_NBITS-1:0] exp;
    logic [2:0]            exp_type;
    opaque_t               exp_opaque;
    len_t                  exp_len;
    data_t                 exp_data;
    if ((port == 0 && exp0_q.size() == 0) || (port == 1 && exp1_q.size() == 0)) begin
      errors++;
      $display("Port %0d returned a response that no request asked for", port);
    end else begin
      if (port == 0) begin
        exp = exp0_q.pop_front();
      end else begin
        exp = exp1_q.pop_front();
      end
      {exp_type, exp_opaque, exp_len, exp_data} = exp;
      check_value(32'(t), 32'(exp_type), $sformatf("port %0d response type", port));
      check_value(32'(op), 32'(exp_opaque), $sformatf("port %0d response opaque", port));
      check_value(32'(l), 32'(exp_len), $sformatf("port %0d response len", port));
      check_value(d, exp_data, $sformatf("port %0d response data", port));
    end
  endtask

  // Sampled at the falling edge, where every input and output is settled
  always @(negedge clk) begin
    if (reset) begin
      // Clear lands before any request taken at the same edge executes
      if (mem_clear) begin
        clear_model();
      end
      if (memreq0_val && memreq0_rdy) begin
        exp0_q.push_back({memreq0_type, memreq0_opaque, memreq0_len,
          apply_to_model(memreq0_type, memreq0_addr, memreq0_len, memreq0_data)});
      end
      if (memreq1_val && memreq1_rdy) begin
        exp1_q.push_back({memreq1_type, memreq1_opaque, memreq1_len,
          apply_to_model(memreq1_type, memreq1_addr, memreq1_len, memreq1_data)});
      end
      if (memresp0_val && memresp0_rdy) begin
        check_resp(0, memresp0_type, memresp0_opaque, memresp0_len, memresp0_data);
      end
      if (memresp1_val && memresp1_rdy) begin
        check_resp(1, memresp1_type, memresp1_opaque, memresp1_len, memresp1_data);
      end
    end
  end

  // Response sink with random stalls while back-pressure is on
  always @(posedge clk) begin
    if (bp_on) begin
      memresp0_rdy <= ($random(seed) & 3) != 0;
      memresp1_rdy <= ($random(seed) & 3) != 0;
    end else begin
      memresp0_rdy <= 1'b1;
      memresp1_rdy <= 1'b1;
    end
  end

  // ----------------------------------------------------------------------------
  // Stimulus tasks start and end just after a rising edge
  // ----------------------------------------------------------------------------

  function automatic logic req_ready(input int port);
    return (port == 0) ? memreq0_rdy : memreq1_rdy;
  endfunction

  function automatic addr_t word_to_addr(input int half, input int word);
    return addr_t'(half * HALF_NBYTES + 4 * word);
  endfunction

  task automatic drive_req(input int port, input req_type_e t, input opaque_t op,
                           input addr_t a, input len_t l, input data_t d);
    int waited;
    waited = 0;
    if (port == 0) begin
      memreq0_val    <= 1'b1;
      memreq0_type   <= t;
      memreq0_opaque <= op;
      memreq0_addr   <= a;
      memreq0_len    <= l;
      memreq0_data   <= d;
    end else begin
      memreq1_val    <= 1'b1;
      memreq1_type   <= t;
      memreq1_opaque <= op;
      memreq1_addr   <= a;
      memreq1_len    <= l;
      memreq1_data   <= d;
    end
    @(negedge clk);
    while (!req_ready(port) && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (!req_ready(port)) begin
      abort_run($sformatf("Port %0d never accepted a request within the timeout", port));
    end else begin
      // Transfer edge; a following call overrides the drop of valid
      @(posedge clk);
      if (port == 0) begin
        memreq0_val <= 1'b0;
      end else begin
        memreq1_val <= 1'b0;
      end
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((exp0_q.size() != 0 || exp1_q.size() != 0) && waited < TIMEOUT_CYCLES) begin
      @(posedge clk);
      waited++;
    end
    if (exp0_q.size() != 0 || exp1_q.size() != 0) begin
      abort_run("Responses still missing after the timeout");
    end
  endtask

  task automatic pulse_clear();
    mem_clear <= 1'b1;
    @(posedge clk);
    mem_clear <= 1'b0;
  endtask

  // Reads and writes inside one word with random upper address bits
  task automatic random_traffic(input int port, input int count);
    int        n;
    int        off;
    int        word;
    int        phys;
    len_t      l;
    req_type_e t;
    addr_t     a;
    for (int i = 0; i < count; i++) begin
      repeat ($random(seed) & 1) @(posedge clk);
      l    = len_t'($random(seed));
      n    = (l == '0) ? 4 : int'(l);
      off  = ($random(seed) & 32'h7fffffff) % (5 - n);
      word = ($random(seed) & 32'h7fffffff) % (HALF_NBYTES / 4);
      phys = port * HALF_NBYTES + 4 * word + off;
      a    = (addr_t'($random(seed)) & ~addr_t'(`TM_MEM_NBYTES - 1)) | addr_t'(phys);
      t    = (($random(seed) & 1) != 0) ? REQ_WRITE : REQ_READ;
      drive_req(port, t, opaque_t'(i), a, l, data_t'($random(seed)));
    end
  endtask

  // Seed a word, apply one atomic, read the result
  task automatic amo_checks(input int port);
    req_type_e amo_ops [3];
    addr_t     a;
    amo_ops = '{REQ_AMO_ADD, REQ_AMO_AND, REQ_AMO_OR};
    for (int k = 0; k < 3; k++) begin
      a = word_to_addr(port, 8 + k);
      drive_req(port, REQ_WRITE, 8'ha0, a, '0, data_t'($random(seed)));
      drive_req(port, amo_ops[k], 8'ha1, a, '0, data_t'($random(seed)));
      drive_req(port, REQ_READ, 8'ha2, a, '0, '0);
    end
  endtask

  task automatic add_burst(input int port, input int word, input int count);
    for (int i = 0; i < count; i++) begin
      drive_req(port, REQ_AMO_ADD, opaque_t'(192 + i), word_to_addr(port, word), '0,
                data_t'($random(seed) & 32'hffff));
    end
  endtask

  // ----------------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------------

  initial begin
    reset          = 1'b0;
    mem_clear      = 1'b0;
    memreq0_val    = 1'b0;
    memreq0_type   = REQ_READ;
    memreq0_opaque = '0;
    memreq0_addr   = '0;
    memreq0_len    = '0;
    memreq0_data   = '0;
    memreq1_val    = 1'b0;
    memreq1_type   = REQ_READ;
    memreq1_opaque = '0;
    memreq1_addr   = '0;
    memreq1_len    = '0;
    memreq1_data   = '0;
    clear_model();

    repeat (8) @(posedge clk);
    reset <= 1'b1;

    // Idle state after reset
    @(negedge clk);
    check_value(32'(memresp0_val), 32'd0, "port 0 response valid after reset");
    check_value(32'(memresp1_val), 32'd0, "port 1 response valid after reset");
    check_value(32'(memreq0_rdy), 32'd1, "port 0 request ready after reset");
    check_value(32'(memreq1_rdy), 32'd1, "port 1 request ready after reset");
    @(posedge clk);

    // Contents are not reset so start from zeros
    pulse_clear();

    fork
      random_traffic(0, 200);
      random_traffic(1, 200);
    join
    wait_drain();

    fork
      amo_checks(0);
      amo_checks(1);
    join
    wait_drain();

    // Back-pressure with mixed traffic and an add chain per port
    bp_on <= 1'b1;
    fork
      begin
        random_traffic(0, 100);
        add_burst(0, 20, 16);
      end
      begin
        random_traffic(1, 100);
        add_burst(1, 20, 16);
      end
    join
    wait_drain();
    bp_on <= 1'b0;
    fork
      drive_req(0, REQ_READ, 8'hb0, word_to_addr(0, 20), '0, '0);
      drive_req(1, REQ_READ, 8'hb1, word_to_addr(1, 20), '0, '0);
    join
    wait_drain();

    // Write on port 0, read back on port 1
    drive_req(0, REQ_WRITE, 8'h50, word_to_addr(1, 40), '0, data_t'($random(seed)));
    wait_drain();
    drive_req(1, REQ_READ, 8'h51, word_to_addr(1, 40), '0, '0);
    wait_drain();

    // Clear wipes written words on both halves
    for (int k = 0; k < 4; k++) begin
      drive_req(0, REQ_WRITE, 8'h60, word_to_addr(0, 60 + k), '0,
                data_t'($random(seed)) | 32'h1);
      drive_req(1, REQ_WRITE, 8'h61, word_to_addr(1, 60 + k), '0,
                data_t'($random(seed)) | 32'h1);
    end
    wait_drain();
    pulse_clear();
    for (int k = 0; k < 4; k++) begin
      drive_req(0, REQ_READ, 8'h70, word_to_addr(0, 60 + k), '0, '0);
      drive_req(1, REQ_READ, 8'h71, word_to_addr(1, 60 + k), '0, '0);
    end
    wait_drain();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
